// File: source/moi_ni_pkg.sv
// Master network interface definitions

package moi_ni_pkg;

	// ********************************************************************
	// Widths
	// ********************************************************************
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int PERMIT_W = 4;
	localparam int BURDEN_W = 8;
	localparam int NODE_W = 4;
	localparam int KIND_W = 2;

	// Target node sits in the top address bits
	localparam int NODE_ADDR_LSB = 28;

	// Outstanding read limit and its counter width
	localparam int MAX_READS = 4;
	localparam int RD_CNT_W = $clog2(MAX_READS + 1);

	localparam int FWD_DEPTH_LOG2 = 3;
	localparam int BWD_DEPTH_LOG2 = 2;

	// Request packet lengths in flits
	localparam int READ_REQ_FLITS = 2;
	localparam int WRITE_REQ_FLITS = 3;

	// ********************************************************************
	// Packet kinds and flit layout
	// ********************************************************************
	localparam logic [KIND_W-1:0] KIND_READ_REQ = 2'd1;
	localparam logic [KIND_W-1:0] KIND_WRITE_REQ = 2'd2;
	localparam logic [KIND_W-1:0] KIND_READ_RSP = 2'd3;

	localparam int HEAD_RSVD_W = DATA_W - 2 * NODE_W - KIND_W - PERMIT_W - BURDEN_W;

	// Head flit or plain address/data word
	typedef union packed {
		struct packed {
			logic [NODE_W-1:0] dest_node;
			logic [NODE_W-1:0] src_node;
			logic [KIND_W-1:0] kind;
			logic [PERMIT_W-1:0] permit;
			logic [BURDEN_W-1:0] burden;
			logic [HEAD_RSVD_W-1:0] reserved;
		} head;
		logic [DATA_W-1:0] word;
	} flit_u;

endpackage

// File: source/async_flit_fifo.sv
// Dual-clock flit FIFO

`timescale 1ns/100ps

module async_flit_fifo
	import moi_ni_pkg::*;
#(
	parameter int DEPTH_LOG2 = 3
) (
	input  logic wr_clk,
	input  logic rd_clk,
	input  logic arst_n,
	input  logic wr_en,
	input  logic wr_last,
	input  flit_u wr_flit,
	output logic [DEPTH_LOG2:0] wr_space,
	input  logic rd_en,
	output logic rd_valid,
	output logic rd_last,
	output flit_u rd_flit
);

	// Entry is {last, flit}
	logic [DATA_W:0] mem [0:(1 << DEPTH_LOG2) - 1];
	logic [DATA_W:0] rd_entry;

	logic [DEPTH_LOG2:0] wr_bin;
	logic [DEPTH_LOG2:0] wr_bin_next;
	logic [DEPTH_LOG2:0] wr_gray;
	logic [DEPTH_LOG2:0] rd_bin;
	logic [DEPTH_LOG2:0] rd_bin_next;
	logic [DEPTH_LOG2:0] rd_gray;

	// Synchronizer stages
	logic [DEPTH_LOG2:0] rd_gray_s1;
	logic [DEPTH_LOG2:0] rd_gray_s2;
	logic [DEPTH_LOG2:0] wr_gray_s1;
	logic [DEPTH_LOG2:0] wr_gray_s2;

	function automatic logic [DEPTH_LOG2:0] gray2bin(input logic [DEPTH_LOG2:0] g);
		logic [DEPTH_LOG2:0] b;
		b[DEPTH_LOG2] = g[DEPTH_LOG2];
		for (int i = DEPTH_LOG2 - 1; i >= 0; i--) begin
			b[i] = b[i + 1] ^ g[i];
		end
		return b;
	endfunction

	// ********************************************************************
	// Write domain
	// ********************************************************************
	assign wr_bin_next = wr_bin + 1'b1;

	always_ff @(posedge wr_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end else begin
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
			if (wr_en) begin
				wr_bin <= wr_bin_next;
				wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
			end
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_en) begin
			mem[wr_bin[DEPTH_LOG2-1:0]] <= {wr_last, wr_flit};
		end
	end

	// Depth minus fill, read side seen late
	assign wr_space = {1'b1, {DEPTH_LOG2{1'b0}}} - (wr_bin - gray2bin(rd_gray_s2));

	// ********************************************************************
	// Read domain
	// ********************************************************************
	assign rd_bin_next = rd_bin + 1'b1;

	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end else begin
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			if (rd_en) begin
				rd_bin <= rd_bin_next;
				rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
			end
		end
	end

	assign rd_valid = (rd_gray != wr_gray_s2);
	assign rd_entry = mem[rd_bin[DEPTH_LOG2-1:0]];
	assign rd_last = rd_entry[DATA_W];
	assign rd_flit = rd_entry[DATA_W-1:0];

endmodule

// File: source/moi_request_packetizer.sv
// Master request packetizer

`timescale 1ns/100ps

module moi_request_packetizer
	import moi_ni_pkg::*;
#(
	parameter int NODE_ID = 0
) (
	input  logic clk_master,
	input  logic arst_n,
	input  logic rlmqvalid,
	input  logic [ADDR_W-1:0] rlmqaddr,
	input  logic rlmqwrite,
	input  logic [DATA_W-1:0] rlmqwdata,
	input  logic [PERMIT_W-1:0] rlmqwpermit,
	input  logic [BURDEN_W-1:0] rlmqburden,
	input  logic rsp_done,
	output logic [1:0] rlmqdready,
	input  logic [FWD_DEPTH_LOG2:0] wr_space,
	output logic wr_en,
	output logic wr_last,
	output flit_u wr_flit
);

	logic busy;
	logic [1:0] flit_idx;
	logic [RD_CNT_W-1:0] rd_count;
	logic accept_rd;
	logic accept_wr;

	// Captured request
	logic req_write;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [PERMIT_W-1:0] req_permit;
	logic [BURDEN_W-1:0] req_burden;

	// Whole packet must fit before a request is taken
	assign rlmqdready[0] = !busy && (wr_space >= READ_REQ_FLITS) && (rd_count < MAX_READS);
	assign rlmqdready[1] = !busy && (wr_space >= WRITE_REQ_FLITS);

	assign accept_rd = rlmqvalid && !rlmqwrite && rlmqdready[0];
	assign accept_wr = rlmqvalid && rlmqwrite && rlmqdready[1];

	assign wr_en = busy;
	assign wr_last = req_write ? (flit_idx == 2'(WRITE_REQ_FLITS - 1)) :
		(flit_idx == 2'(READ_REQ_FLITS - 1));

	// ********************************************************************
	// Flit sequencing
	// ********************************************************************
	always_ff @(posedge clk_master or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			flit_idx <= 2'd0;
		end else if (accept_rd || accept_wr) begin
			busy <= 1'b1;
			flit_idx <= 2'd0;
		end else if (busy) begin
			if (wr_last) begin
				busy <= 1'b0;
				flit_idx <= 2'd0;
			end else begin
				flit_idx <= flit_idx + 2'd1;
			end
		end
	end

	always_ff @(posedge clk_master) begin
		if (accept_rd || accept_wr) begin
			req_write <= rlmqwrite;
			req_addr <= rlmqaddr;
			req_wdata <= rlmqwdata;
			req_permit <= rlmqwpermit;
			req_burden <= rlmqburden;
		end
	end

	// Head, address, then data for writes
	always_comb begin
		wr_flit = '0;
		case (flit_idx)
			2'd0: begin
				wr_flit.head.dest_node = req_addr[NODE_ADDR_LSB +: NODE_W];
				wr_flit.head.src_node = NODE_W'(NODE_ID);
				wr_flit.head.kind = req_write ? KIND_WRITE_REQ : KIND_READ_REQ;
				wr_flit.head.permit = req_permit;
				wr_flit.head.burden = req_burden;
			end
			2'd1: wr_flit.word = req_addr;
			default: wr_flit.word = req_wdata;
		endcase
	end

	// Reads in flight, released by responses taken by the master
	always_ff @(posedge clk_master or negedge arst_n) begin
		if (!arst_n) begin
			rd_count <= '0;
		end else begin
			case ({accept_rd, rsp_done})
				2'b10: rd_count <= rd_count + 1'b1;
				2'b01: rd_count <= rd_count - 1'b1;
				default: rd_count <= rd_count;
			endcase
		end
	end

endmodule

// File: source/network_port.sv
// Network link port

`timescale 1ns/100ps

module network_port
	import moi_ni_pkg::*;
(
	input  logic clk_network,
	input  logic arst_n,
	input  logic comm_disable,

	// Forward FIFO read side
	input  logic rd_valid,
	input  logic rd_last,
	input  flit_u rd_flit,
	output logic rd_en,

	output logic sfni_valid,
	output logic sfni_last,
	output flit_u sfni_flit,
	input  logic sfni_ready,

	input  logic sbni_valid,
	input  logic sbni_last,
	input  flit_u sbni_flit,
	output logic sbni_ready,

	// Backward FIFO write side
	output logic bwd_wr_en,
	output logic bwd_wr_last,
	output flit_u bwd_wr_flit,
	input  logic [BWD_DEPTH_LOG2:0] bwd_wr_space
);

	// High between a sent head and its last flit
	logic fwd_in_pkt;

	// A new head waits while comm_disable is up
	assign sfni_valid = rd_valid && (fwd_in_pkt || !comm_disable);
	assign sfni_last = rd_last;
	assign sfni_flit = rd_flit;
	assign rd_en = sfni_valid && sfni_ready;

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			fwd_in_pkt <= 1'b0;
		end else if (rd_en) begin
			fwd_in_pkt <= !rd_last;
		end
	end

	// Backward flits go straight into the FIFO
	assign sbni_ready = (bwd_wr_space != '0);
	assign bwd_wr_en = sbni_valid && sbni_ready;
	assign bwd_wr_last = sbni_last;
	assign bwd_wr_flit = sbni_flit;

endmodule

// File: source/moi_response_depacketizer.sv
// Read response depacketizer

`timescale 1ns/100ps

module moi_response_depacketizer
	import moi_ni_pkg::*;
(
	input  logic clk_master,
	input  logic arst_n,

	// Backward FIFO read side
	input  logic rd_valid,
	input  logic rd_last,
	input  flit_u rd_flit,
	output logic rd_en,

	output logic rlmyvalid,
	output logic [DATA_W-1:0] rlmyrdata,
	output logic [BURDEN_W-1:0] rlmyburden,
	input  logic rlmydready,
	output logic rsp_done
);

	logic take;

	assign take = rlmyvalid && rlmydready;
	assign rsp_done = take;

	// Nothing is popped while a response is waiting
	assign rd_en = rd_valid && !rlmyvalid;

	always_ff @(posedge clk_master or negedge arst_n) begin
		if (!arst_n) begin
			rlmyvalid <= 1'b0;
		end else if (rd_en && rd_last) begin
			rlmyvalid <= 1'b1;
		end else if (take) begin
			rlmyvalid <= 1'b0;
		end
	end

	// ********************************************************************
	// Output registers
	// ********************************************************************
	// Head carries the burden, the last flit carries the data
	always_ff @(posedge clk_master) begin
		if (rd_en) begin
			if (rd_last) begin
				rlmyrdata <= rd_flit.word;
			end else begin
				rlmyburden <= rd_flit.head.burden;
			end
		end
	end

endmodule

// File: source/moi_ni_top.sv
// Master network interface top

`timescale 1ns/100ps

module moi_ni_top
	import moi_ni_pkg::*;
#(
	parameter int NODE_ID = 0
) (
	input  logic clk_master,
	input  logic clk_network,
	input  logic arst_n,
	input  logic comm_disable,

	// Master request and response
	input  logic rlmqvalid,
	input  logic [ADDR_W-1:0] rlmqaddr,
	input  logic rlmqwrite,
	input  logic [DATA_W-1:0] rlmqwdata,
	input  logic [PERMIT_W-1:0] rlmqwpermit,
	input  logic [BURDEN_W-1:0] rlmqburden,
	output logic [1:0] rlmqdready,
	output logic rlmyvalid,
	output logic [DATA_W-1:0] rlmyrdata,
	output logic [BURDEN_W-1:0] rlmyburden,
	input  logic rlmydready,

	// Network links
	output logic sfni_valid,
	output logic sfni_last,
	output flit_u sfni_flit,
	input  logic sfni_ready,
	input  logic sbni_valid,
	input  logic sbni_last,
	input  flit_u sbni_flit,
	output logic sbni_ready
);

	// Forward path, master to network
	logic fwd_wr_en;
	logic fwd_wr_last;
	flit_u fwd_wr_flit;
	logic [FWD_DEPTH_LOG2:0] fwd_wr_space;
	logic fwd_rd_en;
	logic fwd_rd_valid;
	logic fwd_rd_last;
	flit_u fwd_rd_flit;

	// Backward path, network to master
	logic bwd_wr_en;
	logic bwd_wr_last;
	flit_u bwd_wr_flit;
	logic [BWD_DEPTH_LOG2:0] bwd_wr_space;
	logic bwd_rd_en;
	logic bwd_rd_valid;
	logic bwd_rd_last;
	flit_u bwd_rd_flit;

	logic rsp_done;

	moi_request_packetizer #(
		.NODE_ID(NODE_ID)
	) u_packetizer (
		.clk_master(clk_master),
		.arst_n(arst_n),
		.rlmqvalid(rlmqvalid),
		.rlmqaddr(rlmqaddr),
		.rlmqwrite(rlmqwrite),
		.rlmqwdata(rlmqwdata),
		.rlmqwpermit(rlmqwpermit),
		.rlmqburden(rlmqburden),
		.rsp_done(rsp_done),
		.rlmqdready(rlmqdready),
		.wr_space(fwd_wr_space),
		.wr_en(fwd_wr_en),
		.wr_last(fwd_wr_last),
		.wr_flit(fwd_wr_flit)
	);

	async_flit_fifo #(
		.DEPTH_LOG2(FWD_DEPTH_LOG2)
	) u_fwd_fifo (
		.wr_clk(clk_master),
		.rd_clk(clk_network),
		.arst_n(arst_n),
		.wr_en(fwd_wr_en),
		.wr_last(fwd_wr_last),
		.wr_flit(fwd_wr_flit),
		.wr_space(fwd_wr_space),
		.rd_en(fwd_rd_en),
		.rd_valid(fwd_rd_valid),
		.rd_last(fwd_rd_last),
		.rd_flit(fwd_rd_flit)
	);

	network_port u_network_port (
		.clk_network(clk_network),
		.arst_n(arst_n),
		.comm_disable(comm_disable),
		.rd_valid(fwd_rd_valid),
		.rd_last(fwd_rd_last),
		.rd_flit(fwd_rd_flit),
		.rd_en(fwd_rd_en),
		.sfni_valid(sfni_valid),
		.sfni_last(sfni_last),
		.sfni_flit(sfni_flit),
		.sfni_ready(sfni_ready),
		.sbni_valid(sbni_valid),
		.sbni_last(sbni_last),
		.sbni_flit(sbni_flit),
		.sbni_ready(sbni_ready),
		.bwd_wr_en(bwd_wr_en),
		.bwd_wr_last(bwd_wr_last),
		.bwd_wr_flit(bwd_wr_flit),
		.bwd_wr_space(bwd_wr_space)
	);

	async_flit_fifo #(
		.DEPTH_LOG2(BWD_DEPTH_LOG2)
	) u_bwd_fifo (
		.wr_clk(clk_network),
		.rd_clk(clk_master),
		.arst_n(arst_n),
		.wr_en(bwd_wr_en),
		.wr_last(bwd_wr_last),
		.wr_flit(bwd_wr_flit),
		.wr_space(bwd_wr_space),
		.rd_en(bwd_rd_en),
		.rd_valid(bwd_rd_valid),
		.rd_last(bwd_rd_last),
		.rd_flit(bwd_rd_flit)
	);

	moi_response_depacketizer u_depacketizer (
		.clk_master(clk_master),
		.arst_n(arst_n),
		.rd_valid(bwd_rd_valid),
		.rd_last(bwd_rd_last),
		.rd_flit(bwd_rd_flit),
		.rd_en(bwd_rd_en),
		.rlmyvalid(rlmyvalid),
		.rlmyrdata(rlmyrdata),
		.rlmyburden(rlmyburden),
		.rlmydready(rlmydready),
		.rsp_done(rsp_done)
	);

endmodule

// File: tb/moi_ni_asserts.sv
// Network port link checks

`timescale 1ns/100ps

module moi_ni_asserts
	import moi_ni_pkg::*;
(
	input  logic clk_network,
	input  logic arst_n,
	input  logic comm_disable,
	input  logic sfni_valid,
	input  logic sfni_last,
	input  flit_u sfni_flit,
	input  logic sfni_ready,
	input  logic bwd_wr_en,
	input  logic [BWD_DEPTH_LOG2:0] bwd_wr_space
);

	// Packet state as seen on the forward link
	logic link_in_pkt;

	always_ff @(posedge clk_network or negedge arst_n) begin
		if (!arst_n) begin
			link_in_pkt <= 1'b0;
		end else if (sfni_valid && sfni_ready) begin
			link_in_pkt <= !sfni_last;
		end
	end

	// A stalled flit stays put until it is taken
	a_flit_held: assert property (@(posedge clk_network) disable iff (!arst_n)
		(sfni_valid && !sfni_ready) |=> ($stable(sfni_flit) && $stable(sfni_last)))
		else $error("Forward flit changed while the link was stalled");

	// New heads wait for comm_disable to fall
	a_no_head_disabled: assert property (@(posedge clk_network) disable iff (!arst_n)
		(sfni_valid && !link_in_pkt) |-> !comm_disable)
		else $error("Forward head offered while comm_disable was high");

	// Fill seen by the writer never goes past the depth
	a_bwd_space: assert property (@(posedge clk_network) disable iff (!arst_n)
		bwd_wr_en |=> (bwd_wr_space <= {1'b1, {BWD_DEPTH_LOG2{1'b0}}}))
		else $error("Backward FIFO written without free space");

endmodule

bind network_port moi_ni_asserts u_link_asserts (
	.clk_network(clk_network),
	.arst_n(arst_n),
	.comm_disable(comm_disable),
	.sfni_valid(sfni_valid),
	.sfni_last(sfni_last),
	.sfni_flit(sfni_flit),
	.sfni_ready(sfni_ready),
	.bwd_wr_en(bwd_wr_en),
	.bwd_wr_space(bwd_wr_space)
);

// File: tb/moi_ni_tb.sv
// Network interface testbench

`timescale 1ns/100ps

module moi_ni_tb
	import moi_ni_pkg::*;
();

	localparam int NODE_ID = 3;
	// About ten times the length of all tests together
	localparam int CYCLE_LIMIT = 20000;

	logic clk_master = 1'b0;
	logic clk_network = 1'b0;
	logic arst_n;
	logic comm_disable;
	logic rlmqvalid;
	logic [ADDR_W-1:0] rlmqaddr;
	logic rlmqwrite;
	logic [DATA_W-1:0] rlmqwdata;
	logic [PERMIT_W-1:0] rlmqwpermit;
	logic [BURDEN_W-1:0] rlmqburden;
	logic [1:0] rlmqdready;
	logic rlmyvalid;
	logic [DATA_W-1:0] rlmyrdata;
	logic [BURDEN_W-1:0] rlmyburden;
	logic rlmydready = 1'b0;
	logic sfni_valid;
	logic sfni_last;
	flit_u sfni_flit;
	logic sfni_ready = 1'b0;
	logic sbni_valid = 1'b0;
	logic sbni_last = 1'b0;
	flit_u sbni_flit = '0;
	logic sbni_ready;

	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int cycle_count = 0;
	int pkt_count = 0;
	logic [31:0] rng_state = 32'hb149a0d4;

	// Requests sent, in order, and the reads still to be answered
	logic exp_write [$];
	logic [ADDR_W-1:0] exp_addr [$];
	logic [DATA_W-1:0] exp_data [$];
	logic [PERMIT_W-1:0] exp_permit [$];
	logic [BURDEN_W-1:0] exp_burden [$];
	logic [DATA_W-1:0] exp_rsp_data [$];
	logic [BURDEN_W-1:0] exp_rsp_burden [$];
	logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];

	// Network model state
	logic [DATA_W-1:0] net_mem [logic [ADDR_W-1:0]];
	flit_u net_pkt [$];
	flit_u rsp_flit_q [$];
	logic rsp_last_q [$];
	logic net_in_pkt = 1'b0;
	logic net_rand = 1'b0;
	logic rsp_hold = 1'b0;
	logic bwd_present = 1'b0;
	logic fwd_stalled = 1'b0;
	flit_u stall_flit;
	logic stall_last;
	logic [31:0] net_rnd;

	// Master response side
	logic hold_rsp_ready = 1'b0;
	logic rsp_stalled = 1'b0;
	logic [DATA_W-1:0] stall_rdata;
	logic [BURDEN_W-1:0] stall_burden;

	always #50 clk_master = ~clk_master;
	always #35 clk_network = ~clk_network;

	moi_ni_top #(
		.NODE_ID(NODE_ID)
	) dut (
		.clk_master(clk_master),
		.clk_network(clk_network),
		.arst_n(arst_n),
		.comm_disable(comm_disable),
		.rlmqvalid(rlmqvalid),
		.rlmqaddr(rlmqaddr),
		.rlmqwrite(rlmqwrite),
		.rlmqwdata(rlmqwdata),
		.rlmqwpermit(rlmqwpermit),
		.rlmqburden(rlmqburden),
		.rlmqdready(rlmqdready),
		.rlmyvalid(rlmyvalid),
		.rlmyrdata(rlmyrdata),
		.rlmyburden(rlmyburden),
		.rlmydready(rlmydready),
		.sfni_valid(sfni_valid),
		.sfni_last(sfni_last),
		.sfni_flit(sfni_flit),
		.sfni_ready(sfni_ready),
		.sbni_valid(sbni_valid),
		.sbni_last(sbni_last),
		.sbni_flit(sbni_flit),
		.sbni_ready(sbni_ready)
	);

	// ********************************************************************
	// Helpers and compare tasks
	// ********************************************************************
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [DATA_W-1:0] unwritten_word(input logic [ADDR_W-1:0] addr);
		return addr ^ 32'h5a5a5a5a;
	endfunction

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
			input logic [DATA_W-1:0] new_word, input logic [PERMIT_W-1:0] permit);
		logic [DATA_W-1:0] res;
		res = old_word;
		for (int i = 0; i < PERMIT_W; i++) begin
			if (permit[i]) begin
				res[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return res;
	endfunction

	task automatic report_failure(input string msg);
		err_count++;
		$display("%s", msg);
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] act,
			input logic [DATA_W-1:0] exp);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("error %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic check_flit(input string name, input flit_u act, input flit_u exp);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("error %s: got %h, expected %h", name, act.word, exp.word);
		end
	endtask

	task automatic check_burden(input string name, input logic [BURDEN_W-1:0] act,
			input logic [BURDEN_W-1:0] exp);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("error %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic check_bits(input string name, input logic [1:0] act, input logic [1:0] exp);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("error %s: got %h, expected %h", name, act, exp);
		end
	endtask

	// ********************************************************************
	// Network model
	// ********************************************************************
	task automatic handle_packet();
		flit_u exp_head;
		flit_u rsp_head;
		logic wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [PERMIT_W-1:0] permit;
		logic [BURDEN_W-1:0] burden;
		logic [DATA_W-1:0] word;
		pkt_count++;
		if (exp_addr.size() == 0) begin
			report_failure("Forward packet arrived with no request outstanding");
		end else begin
			wr = exp_write.pop_front();
			addr = exp_addr.pop_front();
			data = exp_data.pop_front();
			permit = exp_permit.pop_front();
			burden = exp_burden.pop_front();
			exp_head = '0;
			exp_head.head.dest_node = addr[NODE_ADDR_LSB +: NODE_W];
			exp_head.head.src_node = NODE_W'(NODE_ID);
			exp_head.head.kind = wr ? KIND_WRITE_REQ : KIND_READ_REQ;
			exp_head.head.permit = permit;
			exp_head.head.burden = burden;
			check_flit("sfni_flit head", net_pkt[0], exp_head);
			if (net_pkt.size() != (wr ? WRITE_REQ_FLITS : READ_REQ_FLITS)) begin
				report_failure($sformatf("Forward packet ended after %0d flits", net_pkt.size()));
			end else begin
				check_word("sfni_flit address", net_pkt[1].word, addr);
				addr = net_pkt[1].word;
				word = net_mem.exists(addr) ? net_mem[addr] : unwritten_word(addr);
				if (wr) begin
					check_word("sfni_flit data", net_pkt[2].word, data);
					net_mem[addr] = merge_bytes(word, net_pkt[2].word, net_pkt[0].head.permit);
				end else begin
					rsp_head = '0;
					rsp_head.head.dest_node = net_pkt[0].head.src_node;
					rsp_head.head.src_node = net_pkt[0].head.dest_node;
					rsp_head.head.kind = KIND_READ_RSP;
					rsp_head.head.burden = net_pkt[0].head.burden;
					rsp_flit_q.push_back(rsp_head);
					rsp_last_q.push_back(1'b0);
					rsp_flit_q.push_back(word);
					rsp_last_q.push_back(1'b1);
				end
			end
		end
		net_pkt.delete();
	endtask

	// Links are set up on the falling edge, transfers decided just after it
	always @(negedge clk_network) begin
		net_rnd = next_random();
		sfni_ready = net_rand ? (net_rnd[0] | net_rnd[1]) : 1'b1;
		if (!bwd_present) begin
			if (rsp_flit_q.size() != 0 && !rsp_hold && !(net_rand && net_rnd[2] && net_rnd[3])) begin
				sbni_valid = 1'b1;
				sbni_flit = rsp_flit_q[0];
				sbni_last = rsp_last_q[0];
				bwd_present = 1'b1;
			end else begin
				sbni_valid = 1'b0;
			end
		end
		#1;
		if (sfni_valid) begin
			if (fwd_stalled) begin
				check_flit("sfni_flit", sfni_flit, stall_flit);
				check_bits("sfni_last", {1'b0, sfni_last}, {1'b0, stall_last});
			end
			if (!net_in_pkt && comm_disable) begin
				report_failure("A packet started on the forward link while comm_disable was high");
			end
			if (sfni_ready) begin
				fwd_stalled = 1'b0;
				net_pkt.push_back(sfni_flit);
				net_in_pkt = !sfni_last;
				if (sfni_last) begin
					handle_packet();
				end
			end else begin
				fwd_stalled = 1'b1;
				stall_flit = sfni_flit;
				stall_last = sfni_last;
			end
		end else begin
			fwd_stalled = 1'b0;
		end
		if (sbni_valid && sbni_ready) begin
			void'(rsp_flit_q.pop_front());
			void'(rsp_last_q.pop_front());
			bwd_present = 1'b0;
		end
	end

	// Master response collector
	always @(negedge clk_master) begin
		rlmydready = !hold_rsp_ready;
		#1;
		if (rlmyvalid) begin
			if (rsp_stalled) begin
				check_word("rlmyrdata", rlmyrdata, stall_rdata);
				check_burden("rlmyburden", rlmyburden, stall_burden);
			end
			if (rlmydready) begin
				rsp_stalled = 1'b0;
				if (exp_rsp_data.size() == 0) begin
					report_failure("Response arrived with no read outstanding");
				end else begin
					check_word("rlmyrdata", rlmyrdata, exp_rsp_data.pop_front());
					check_burden("rlmyburden", rlmyburden, exp_rsp_burden.pop_front());
				end
			end else begin
				rsp_stalled = 1'b1;
				stall_rdata = rlmyrdata;
				stall_burden = rlmyburden;
			end
		end else begin
			if (rsp_stalled) begin
				report_failure("rlmyvalid dropped before the response was taken");
			end
			rsp_stalled = 1'b0;
		end
	end

	always @(posedge clk_master) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d master cycles without finishing", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	// ********************************************************************
	// Master request driver
	// ********************************************************************
	task automatic send_request(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [PERMIT_W-1:0] permit,
			input logic [BURDEN_W-1:0] burden);
		logic [DATA_W-1:0] old_word;
		@(negedge clk_master);
		rlmqvalid = 1'b1;
		rlmqwrite = write;
		rlmqaddr = addr;
		rlmqwdata = data;
		rlmqwpermit = permit;
		rlmqburden = burden;
		#1;
		while (!rlmqdready[write]) begin
			@(negedge clk_master);
			#1;
		end
		// Taken on the coming rising edge
		old_word = ref_mem.exists(addr) ? ref_mem[addr] : unwritten_word(addr);
		exp_write.push_back(write);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_permit.push_back(permit);
		exp_burden.push_back(burden);
		if (write) begin
			ref_mem[addr] = merge_bytes(old_word, data, permit);
		end else begin
			exp_rsp_data.push_back(old_word);
			exp_rsp_burden.push_back(burden);
		end
		@(negedge clk_master);
		rlmqvalid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_addr.size() != 0 || exp_rsp_data.size() != 0 || rsp_flit_q.size() != 0
				|| rlmyvalid) begin
			@(negedge clk_master);
		end
		repeat (4) @(negedge clk_master);
	endtask

	task automatic wait_ready_level(input logic [1:0] level);
		int n;
		n = 0;
		@(negedge clk_master);
		#1;
		while (rlmqdready !== level && n < 200) begin
			@(negedge clk_master);
			#1;
			n++;
		end
		check_bits("rlmqdready", rlmqdready, level);
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_count++;
		$display("test %s finished with %0d errors", name, err_count - errs_before);
	endtask

	// ********************************************************************
	// Directed tests
	// ********************************************************************
	task automatic reset_levels();
		int errs;
		errs = err_count;
		@(negedge clk_master);
		#1;
		check_bits("rlmqdready", rlmqdready, 2'b11);
		check_bits("sfni_valid", {1'b0, sfni_valid}, 2'b00);
		check_bits("rlmyvalid", {1'b0, rlmyvalid}, 2'b00);
		check_bits("sbni_ready", {1'b0, sbni_ready}, 2'b01);
		end_test("reset_levels", errs);
	endtask

	task automatic write_then_read();
		int errs;
		errs = err_count;
		send_request(1'b1, 32'h5000_0040, 32'h1122_3344, 4'hf, 8'h01);
		send_request(1'b1, 32'h5000_0040, 32'haabb_ccdd, 4'b0101, 8'h02);
		send_request(1'b1, 32'h9000_0080, 32'hdead_beef, 4'b1000, 8'h03);
		send_request(1'b0, 32'h5000_0040, 32'h0, 4'hf, 8'h11);
		send_request(1'b0, 32'h9000_0080, 32'h0, 4'hf, 8'h12);
		send_request(1'b0, 32'h2000_00c0, 32'h0, 4'hf, 8'h13);
		wait_idle();
		end_test("write_then_read", errs);
	endtask

	task automatic packet_format();
		int errs;
		int pkts;
		errs = err_count;
		pkts = pkt_count;
		send_request(1'b1, 32'he000_1004, 32'h0102_0304, 4'b0011, 8'ha5);
		send_request(1'b0, 32'h0000_2008, 32'h0, 4'b0110, 8'h5a);
		send_request(1'b1, 32'hf000_300c, 32'hcafe_f00d, 4'b1100, 8'hff);
		send_request(1'b0, 32'he000_1004, 32'h0, 4'b1001, 8'h00);
		wait_idle();
		if (pkt_count != pkts + 4) begin
			report_failure("Wrong number of forward packets in the format test");
		end
		end_test("packet_format", errs);
	endtask

	task automatic read_limit();
		int errs;
		errs = err_count;
		rsp_hold = 1'b1;
		for (int i = 0; i < MAX_READS; i++) begin
			send_request(1'b0, 32'h4000_0200 + 32'(4 * i), 32'h0, 4'hf, 8'h40 + 8'(i));
		end
		wait_ready_level(2'b10);
		send_request(1'b1, 32'h4000_0300, 32'h7788_99aa, 4'hf, 8'h4f);
		wait_ready_level(2'b10);
		rsp_hold = 1'b0;
		wait_idle();
		wait_ready_level(2'b11);
		end_test("read_limit", errs);
	endtask

	task automatic response_backpressure();
		int errs;
		errs = err_count;
		hold_rsp_ready = 1'b1;
		send_request(1'b0, 32'h5000_0040, 32'h0, 4'hf, 8'h21);
		send_request(1'b0, 32'h9000_0080, 32'h0, 4'hf, 8'h22);
		send_request(1'b0, 32'h4000_0300, 32'h0, 4'hf, 8'h23);
		send_request(1'b0, 32'h8000_0010, 32'h0, 4'hf, 8'h24);
		while (!rlmyvalid) begin
			@(negedge clk_master);
		end
		repeat (20) @(negedge clk_master);
		check_bits("sbni_ready", {1'b0, sbni_ready}, 2'b00);
		hold_rsp_ready = 1'b0;
		wait_idle();
		end_test("response_backpressure", errs);
	endtask

	task automatic pause_on_comm_disable();
		int errs;
		int pkts;
		errs = err_count;
		pkts = pkt_count;
		send_request(1'b1, 32'h6000_0100, 32'h3141_5926, 4'hf, 8'h31);
		while (!net_in_pkt) begin
			@(negedge clk_network);
		end
		comm_disable = 1'b1;
		send_request(1'b0, 32'h6000_0100, 32'h0, 4'hf, 8'h32);
		send_request(1'b1, 32'h7000_0104, 32'h2718_2818, 4'b0110, 8'h33);
		repeat (30) @(negedge clk_master);
		if (pkt_count != pkts + 1) begin
			report_failure("Forward packet count was wrong while comm_disable was high");
		end
		@(negedge clk_network);
		comm_disable = 1'b0;
		wait_idle();
		if (pkt_count != pkts + 3) begin
			report_failure("Queued packets did not follow after comm_disable fell");
		end
		end_test("pause_on_comm_disable", errs);
	endtask

	task automatic random_traffic();
		int errs;
		logic [31:0] rnd;
		logic [ADDR_W-1:0] addr;
		errs = err_count;
		net_rand = 1'b1;
		for (int i = 0; i < 60; i++) begin
			rnd = next_random();
			addr = {rnd[7:4], 23'h0, rnd[10:8], 2'b00};
			send_request(rnd[0], addr, next_random(), rnd[15:12], rnd[23:16]);
		end
		wait_idle();
		net_rand = 1'b0;
		repeat (4) @(negedge clk_master);
		end_test("random_traffic", errs);
	endtask

	initial begin
		arst_n = 1'b0;
		comm_disable = 1'b0;
		rlmqvalid = 1'b0;
		rlmqaddr = '0;
		rlmqwrite = 1'b0;
		rlmqwdata = '0;
		rlmqwpermit = '0;
		rlmqburden = '0;
		repeat (8) @(posedge clk_master);
		@(negedge clk_master);
		arst_n = 1'b1;
		reset_levels();
		write_then_read();
		packet_format();
		read_limit();
		response_backpressure();
		pause_on_comm_disable();
		random_traffic();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: all.f
source/moi_ni_pkg.sv
source/async_flit_fifo.sv
source/moi_request_packetizer.sv
source/network_port.sv
source/moi_response_depacketizer.sv
source/moi_ni_top.sv
tb/moi_ni_asserts.sv
tb/moi_ni_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f all.f --top-module moi_ni_tb --Mdir obj_dir -o moi_ni_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/moi_ni_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed" sim.log; then
	echo "Simulation log holds no result"
	exit 1
fi
exit 0
